/* filelist.f */
+incdir+test
verilog/eth_ingress_pkg.sv
verilog/vlan_untagger.sv
verilog/ingress_frame_buffer.sv
verilog/ingress_stats.sv
verilog/eth_ingress_port.sv
test/eth_ingress_port_tb.sv

/* Bender.yml */
package:
  name: eth_ingress_port

sources:
  - files:
      - verilog/eth_ingress_pkg.sv
      - verilog/vlan_untagger.sv
      - verilog/ingress_frame_buffer.sv
      - verilog/ingress_stats.sv
      - verilog/eth_ingress_port.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/eth_ingress_port_tb.sv

/* test/eth_ingress_frames.svh */
// One row per test frame
// Columns are tagged allowed, untagged allowed, port VLAN, tagged, VID, length in words,
// drop before word (0 for none), frames queued before reading, expected outcome

typedef enum logic [1:0] {
	FORWARDED,
	POLICY,
	UPSTREAM,
	OVERFLOW
} outcome_t;

typedef struct packed {
	logic       tag_ok;
	logic       untag_ok;
	vlan_id_t   port_vlan;
	logic       has_tag;
	vlan_id_t   vid;
	frame_len_t len;
	frame_len_t drop_at;
	logic [3:0] queue;
	outcome_t   outcome;
} frame_row_t;

localparam int NUM_ROWS = 19;

frame_row_t frame_table [NUM_ROWS];

task automatic load_frame_table();
	// Native, trunk, access and disabled modes with both frame kinds
	frame_table[0]  = '{1'b1, 1'b1, 12'd10, 1'b0, 12'd0,   10'd8,  10'd0, 4'd1, FORWARDED};
	frame_table[1]  = '{1'b1, 1'b1, 12'd10, 1'b1, 12'd100, 10'd8,  10'd0, 4'd1, FORWARDED};
	frame_table[2]  = '{1'b1, 1'b0, 12'd20, 1'b1, 12'd200, 10'd6,  10'd0, 4'd1, FORWARDED};
	frame_table[3]  = '{1'b1, 1'b0, 12'd20, 1'b0, 12'd0,   10'd6,  10'd0, 4'd1, POLICY};
	frame_table[4]  = '{1'b0, 1'b1, 12'd30, 1'b0, 12'd0,   10'd7,  10'd0, 4'd1, FORWARDED};
	frame_table[5]  = '{1'b0, 1'b1, 12'd30, 1'b1, 12'd300, 10'd7,  10'd0, 4'd1, POLICY};
	frame_table[6]  = '{1'b0, 1'b0, 12'd40, 1'b0, 12'd0,   10'd5,  10'd0, 4'd1, POLICY};
	frame_table[7]  = '{1'b0, 1'b0, 12'd40, 1'b1, 12'd400, 10'd5,  10'd0, 4'd1, POLICY};
	// Upstream drop in mid frame, the next frame must come through whole
	frame_table[8]  = '{1'b1, 1'b1, 12'd10, 1'b0, 12'd0,   10'd10, 10'd6, 4'd1, UPSTREAM};
	frame_table[9]  = '{1'b1, 1'b1, 12'd10, 1'b0, 12'd0,   10'd9,  10'd0, 4'd1, FORWARDED};
	frame_table[10] = '{1'b1, 1'b1, 12'd10, 1'b1, 12'h123, 10'd10, 10'd5, 4'd1, UPSTREAM};
	frame_table[11] = '{1'b1, 1'b1, 12'd10, 1'b1, 12'h456, 10'd6,  10'd0, 4'd1, FORWARDED};
	// Back pressure, 43 words queued then a frame too big for the rest
	frame_table[12] = '{1'b1, 1'b1, 12'd50, 1'b0, 12'd0,   10'd20, 10'd0, 4'd9, FORWARDED};
	frame_table[13] = '{1'b1, 1'b1, 12'd50, 1'b1, 12'h0ab, 10'd24, 10'd0, 4'd9, FORWARDED};
	frame_table[14] = '{1'b1, 1'b1, 12'd50, 1'b0, 12'd0,   10'd30, 10'd0, 4'd9, OVERFLOW};
	frame_table[15] = '{1'b1, 1'b1, 12'd51, 1'b0, 12'd0,   10'd12, 10'd0, 4'd9, FORWARDED};
	frame_table[16] = '{1'b1, 1'b1, 12'd51, 1'b1, 12'h7ff, 10'd5,  10'd0, 4'd9, FORWARDED};
	// Metadata queue is full now, this one is lost at its start
	frame_table[17] = '{1'b1, 1'b1, 12'd52, 1'b0, 12'd0,   10'd4,  10'd0, 4'd1, OVERFLOW};
	frame_table[18] = '{1'b1, 1'b1, 12'd53, 1'b0, 12'd0,   10'd8,  10'd0, 4'd1, FORWARDED};
endtask

/* test/eth_ingress_port_tb.sv */
`timescale 1ns/1ps

// Testbench for the ingress port, frames from a table, payload from an LCG
module eth_ingress_port_tb import eth_ingress_pkg::*; ();

	localparam int BUF_WORDS  = 64;
	localparam int META_DEPTH = 4;

	// Commit to counter update is untagger, buffer and stats, one cycle each
	localparam int SETTLE_CYCLES = 4;

	`include "eth_ingress_frames.svh"

	logic         clk;
	logic         reset;
	vlan_id_t     port_vlan;
	logic         tagged_allowed;
	logic         untagged_allowed;
	logic         rx_start;
	logic         rx_data_valid;
	word_t        rx_data;
	bytes_valid_t rx_bytes_valid;
	logic         rx_commit;
	logic         rx_drop;
	logic         pop;
	logic         frame_avail;
	vlan_id_t     frame_vlan;
	frame_len_t   frame_len;
	logic         out_valid;
	word_t        out_data;
	bytes_valid_t out_bytes_valid;
	logic         out_last;
	stat_count_t  forwarded_count;
	stat_count_t  policy_drop_count;
	stat_count_t  upstream_drop_count;
	stat_count_t  overflow_count;

	// Expected frames still waiting in the buffer, oldest first
	word_t        exp_words [$];
	bytes_valid_t exp_bytes [$];
	vlan_id_t     exp_vlan [$];
	int           exp_len [$];

	// Expected counter values
	int exp_forwarded;
	int exp_policy;
	int exp_upstream;
	int exp_overflow;

	logic [31:0] lcg_state;
	int          row_errors;
	int          pass_count;
	int          fail_count;
	int          cycle_count = 0;
	int          cycle_limit;

	// Set whenever frame_avail is high at a clock edge
	logic        avail_seen;

	eth_ingress_port #(
		.BUF_WORDS  (BUF_WORDS),
		.META_DEPTH (META_DEPTH)
	) DUT (
		.clk                 (clk),
		.reset               (reset),
		.port_vlan           (port_vlan),
		.tagged_allowed      (tagged_allowed),
		.untagged_allowed    (untagged_allowed),
		.rx_start            (rx_start),
		.rx_data_valid       (rx_data_valid),
		.rx_data             (rx_data),
		.rx_bytes_valid      (rx_bytes_valid),
		.rx_commit           (rx_commit),
		.rx_drop             (rx_drop),
		.pop                 (pop),
		.frame_avail         (frame_avail),
		.frame_vlan          (frame_vlan),
		.frame_len           (frame_len),
		.out_valid           (out_valid),
		.out_data            (out_data),
		.out_bytes_valid     (out_bytes_valid),
		.out_last            (out_last),
		.forwarded_count     (forwarded_count),
		.policy_drop_count   (policy_drop_count),
		.upstream_drop_count (upstream_drop_count),
		.overflow_count      (overflow_count)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		if (frame_avail)
			avail_seen = 1'b1;
	end

	// Run limit from the table lengths
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout, the run did not finish within %0d cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic word_t next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Inputs change just after the rising edge
	task automatic step_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
			row_errors++;
		end
	endtask

	// Drives one frame and queues its expected words if it should be kept
	task automatic send_frame(input frame_row_t row);
		word_t        w;
		bytes_valid_t bv;
		int           n;
		int           i;
		tagged_allowed   = row.tag_ok;
		untagged_allowed = row.untag_ok;
		port_vlan        = row.port_vlan;
		n = (row.drop_at != 0) ? int'(row.drop_at) : int'(row.len);
		rx_start = 1'b1;
		step_cycle();
		rx_start = 1'b0;
		for (i = 0; i < n; i++) begin
			w  = next_random();
			bv = 3'd4;
			if (i == VLAN_TAG_WORD) begin
				if (row.has_tag)
					w = {16'h8100, 4'h0, row.vid};
				else if (w[31:16] == 16'h8100)
					w[16] = ~w[16];
			end
			// Short last word
			if (i == row.len - 1)
				bv = 3'(((next_random() >> 16) % 4) + 1);
			rx_data_valid  = 1'b1;
			rx_data        = w;
			rx_bytes_valid = bv;
			// Tag word never reaches the buffer
			if (row.outcome == FORWARDED && !(row.has_tag && i == VLAN_TAG_WORD)) begin
				exp_words.push_back(w);
				exp_bytes.push_back(bv);
			end
			step_cycle();
		end
		rx_data_valid  = 1'b0;
		rx_data        = '0;
		rx_bytes_valid = '0;
		if (row.drop_at != 0)
			rx_drop = 1'b1;
		else
			rx_commit = 1'b1;
		step_cycle();
		rx_drop   = 1'b0;
		rx_commit = 1'b0;
		if (row.outcome == FORWARDED) begin
			exp_vlan.push_back(row.has_tag ? row.vid : row.port_vlan);
			exp_len.push_back(row.has_tag ? int'(row.len) - 1 : int'(row.len));
		end
	endtask

	// Pops every queued frame back to back and compares metadata and words
	task automatic drain_frames();
		int n;
		int i;
		while (exp_len.size() > 0) begin
			n = exp_len.pop_front();
			check_value("frame_avail", 1, frame_avail);
			check_value("frame_vlan", exp_vlan.pop_front(), frame_vlan);
			check_value("frame_len", n, frame_len);
			for (i = 0; i < n; i++) begin
				pop = 1'b1;
				step_cycle();
				pop = 1'b0;
				check_value("out_valid", 1, out_valid);
				check_value("out_data", exp_words.pop_front(), out_data);
				check_value("out_bytes_valid", exp_bytes.pop_front(), out_bytes_valid);
				check_value("out_last", i == n - 1, out_last);
			end
		end
		// Empty queue, a stray pop gives nothing
		check_value("frame_avail", 0, frame_avail);
		pop = 1'b1;
		step_cycle();
		pop = 1'b0;
		check_value("out_valid", 0, out_valid);
	endtask

	task automatic check_counters();
		check_value("forwarded_count", exp_forwarded, forwarded_count);
		check_value("policy_drop_count", exp_policy, policy_drop_count);
		check_value("upstream_drop_count", exp_upstream, upstream_drop_count);
		check_value("overflow_count", exp_overflow, overflow_count);
	endtask

	task automatic record_result(input string label);
		if (row_errors == 0)
			pass_count++;
		else
			fail_count++;
		$display("%s %s", label, (row_errors == 0) ? "ok" : "failed");
	endtask

	function automatic string outcome_text(input outcome_t o);
		case (o)
			FORWARDED: return "forwarded";
			POLICY:    return "policy drop";
			UPSTREAM:  return "upstream drop";
			default:   return "overflow";
		endcase
	endfunction

	initial begin
		int         r;
		int         forwarded_rows;
		frame_row_t row;
		clk              = 1'b0;
		reset            = 1'b1;
		port_vlan        = '0;
		tagged_allowed   = 1'b0;
		untagged_allowed = 1'b0;
		rx_start         = 1'b0;
		rx_data_valid    = 1'b0;
		rx_data          = '0;
		rx_bytes_valid   = '0;
		rx_commit        = 1'b0;
		rx_drop          = 1'b0;
		pop              = 1'b0;
		avail_seen       = 1'b0;
		lcg_state        = 32'h89032217;
		exp_forwarded    = 0;
		exp_policy       = 0;
		exp_upstream     = 0;
		exp_overflow     = 0;
		pass_count       = 0;
		fail_count       = 0;
		forwarded_rows   = 0;
		load_frame_table();
		cycle_limit = 0;
		for (r = 0; r < NUM_ROWS; r++)
			cycle_limit += int'(frame_table[r].len) + 40;

		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;

		for (r = 0; r < NUM_ROWS; r++) begin
			row        = frame_table[r];
			row_errors = 0;
			if (exp_len.size() == 0)
				avail_seen = 1'b0;
			send_frame(row);
			repeat (SETTLE_CYCLES) step_cycle();
			case (row.outcome)
				FORWARDED: exp_forwarded++;
				POLICY:    exp_policy++;
				UPSTREAM:  exp_upstream++;
				default:   exp_overflow++;
			endcase
			check_counters();
			// A frame that is not kept must not show up on an empty buffer
			if (row.outcome != FORWARDED && exp_len.size() == 0)
				check_value("frame_avail", 0, avail_seen);
			check_value("frame_avail", exp_len.size() > 0, frame_avail);
			if (exp_len.size() > 0 && exp_len.size() >= row.queue)
				drain_frames();
			record_result($sformatf("row %0d tagged_ok %0b untagged_ok %0b tagged %0b len %0d %s",
				r, row.tag_ok, row.untag_ok, row.has_tag, row.len, outcome_text(row.outcome)));
		end

		// Final tally against the table
		row_errors = 0;
		if (exp_len.size() > 0)
			drain_frames();
		for (r = 0; r < NUM_ROWS; r++) begin
			if (frame_table[r].outcome == FORWARDED)
				forwarded_rows++;
		end
		check_value("forwarded_count", forwarded_rows, forwarded_count);
		record_result("final forwarded count");

		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* verilog/eth_ingress_port.sv */
`timescale 1ns/1ps

// Receive side of one switch port
// MAC bus -> VLAN untagger -> frame buffer -> consumer, with outcome counters
module eth_ingress_port import eth_ingress_pkg::*; #(
	parameter int BUF_WORDS  = 512,
	parameter int META_DEPTH = 8
) (
	input  logic         clk,
	input  logic         reset,

	// Port configuration
	input  vlan_id_t     port_vlan,
	input  logic         tagged_allowed,
	input  logic         untagged_allowed,

	// Receive bus from the MAC
	input  logic         rx_start,
	input  logic         rx_data_valid,
	input  word_t        rx_data,
	input  bytes_valid_t rx_bytes_valid,
	input  logic         rx_commit,
	input  logic         rx_drop,

	// Frame output
	input  logic         pop,
	output logic         frame_avail,
	output vlan_id_t     frame_vlan,
	output frame_len_t   frame_len,
	output logic         out_valid,
	output word_t        out_data,
	output bytes_valid_t out_bytes_valid,
	output logic         out_last,

	// Statistics
	output stat_count_t  forwarded_count,
	output stat_count_t  policy_drop_count,
	output stat_count_t  upstream_drop_count,
	output stat_count_t  overflow_count
);

	// Untagger to buffer
	logic         un_start;
	logic         un_data_valid;
	word_t        un_data;
	bytes_valid_t un_bytes_valid;
	logic         un_commit;
	logic         un_drop;
	logic         un_policy_drop;
	vlan_id_t     un_vlan;
	logic         un_vlan_valid;

	// Buffer to statistics
	logic         frame_committed;
	logic         frame_overflow;
	logic         frame_policy_drop;
	logic         frame_upstream_drop;

	vlan_untagger u_untagger (
		.clk              (clk),
		.reset            (reset),
		.port_vlan        (port_vlan),
		.tagged_allowed   (tagged_allowed),
		.untagged_allowed (untagged_allowed),
		.rx_start         (rx_start),
		.rx_data_valid    (rx_data_valid),
		.rx_data          (rx_data),
		.rx_bytes_valid   (rx_bytes_valid),
		.rx_commit        (rx_commit),
		.rx_drop          (rx_drop),
		.un_start         (un_start),
		.un_data_valid    (un_data_valid),
		.un_data          (un_data),
		.un_bytes_valid   (un_bytes_valid),
		.un_commit        (un_commit),
		.un_drop          (un_drop),
		.un_policy_drop   (un_policy_drop),
		.un_vlan          (un_vlan),
		.un_vlan_valid    (un_vlan_valid)
	);

	ingress_frame_buffer #(
		.BUF_WORDS  (BUF_WORDS),
		.META_DEPTH (META_DEPTH)
	) u_buffer (
		.clk                 (clk),
		.reset               (reset),
		.un_start            (un_start),
		.un_data_valid       (un_data_valid),
		.un_data             (un_data),
		.un_bytes_valid      (un_bytes_valid),
		.un_commit           (un_commit),
		.un_drop             (un_drop),
		.un_policy_drop      (un_policy_drop),
		.un_vlan             (un_vlan),
		.un_vlan_valid       (un_vlan_valid),
		.pop                 (pop),
		.frame_avail         (frame_avail),
		.frame_vlan          (frame_vlan),
		.frame_len           (frame_len),
		.out_valid           (out_valid),
		.out_data            (out_data),
		.out_bytes_valid     (out_bytes_valid),
		.out_last            (out_last),
		.frame_committed     (frame_committed),
		.frame_overflow      (frame_overflow),
		.frame_policy_drop   (frame_policy_drop),
		.frame_upstream_drop (frame_upstream_drop)
	);

	ingress_stats u_stats (
		.clk                 (clk),
		.reset               (reset),
		.frame_committed     (frame_committed),
		.frame_overflow      (frame_overflow),
		.frame_policy_drop   (frame_policy_drop),
		.frame_upstream_drop (frame_upstream_drop),
		.forwarded_count     (forwarded_count),
		.policy_drop_count   (policy_drop_count),
		.upstream_drop_count (upstream_drop_count),
		.overflow_count      (overflow_count)
	);

endmodule

/* verilog/ingress_stats.sv */
`timescale 1ns/1ps

// Frame outcome counters, each one saturates at all ones
module ingress_stats import eth_ingress_pkg::*; (
	input  logic        clk,
	input  logic        reset,

	// One strobe per frame outcome
	input  logic        frame_committed,
	input  logic        frame_overflow,
	input  logic        frame_policy_drop,
	input  logic        frame_upstream_drop,

	output stat_count_t forwarded_count,
	output stat_count_t policy_drop_count,
	output stat_count_t upstream_drop_count,
	output stat_count_t overflow_count
);

	localparam int NUM_COUNTERS = 4;

	// Strobes gathered so one loop serves every counter
	logic [NUM_COUNTERS-1:0] hit;
	stat_count_t             count [NUM_COUNTERS];

	assign hit = {frame_overflow, frame_upstream_drop, frame_policy_drop, frame_committed};

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_COUNTERS; i++)
				count[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_COUNTERS; i++) begin
				// Hold at full scale rather than wrap
				if (hit[i] && (count[i] != '1))
					count[i] <= count[i] + 1'b1;
			end
		end
	end

	// Same order as the strobe vector
	assign forwarded_count     = count[0];
	assign policy_drop_count   = count[1];
	assign upstream_drop_count = count[2];
	assign overflow_count      = count[3];

endmodule

/* verilog/ingress_frame_buffer.sv */
`timescale 1ns/1ps

// Store and forward frame memory with commit and rollback
//
// Words are written speculatively at wr_ptr, commit moves commit_ptr up to it
// and pushes VLAN ID and length into the metadata queue
// Drop or overflow rolls wr_ptr back so committed frames are never touched
// BUF_WORDS and META_DEPTH must be powers of two, META_DEPTH at least 2
module ingress_frame_buffer import eth_ingress_pkg::*; #(
	parameter int BUF_WORDS  = 512,
	parameter int META_DEPTH = 8
) (
	input  logic         clk,
	input  logic         reset,

	// Untagged bus from the untagger
	input  logic         un_start,
	input  logic         un_data_valid,
	input  word_t        un_data,
	input  bytes_valid_t un_bytes_valid,
	input  logic         un_commit,
	input  logic         un_drop,
	input  logic         un_policy_drop,
	input  vlan_id_t     un_vlan,
	input  logic         un_vlan_valid,

	// Consumer side
	input  logic         pop,
	output logic         frame_avail,
	output vlan_id_t     frame_vlan,
	output frame_len_t   frame_len,
	output logic         out_valid,
	output word_t        out_data,
	output bytes_valid_t out_bytes_valid,
	output logic         out_last,

	// Per frame outcome strobes for statistics
	output logic         frame_committed,
	output logic         frame_overflow,
	output logic         frame_policy_drop,
	output logic         frame_upstream_drop
);

	localparam int AW = $clog2(BUF_WORDS);
	localparam int MW = $clog2(META_DEPTH);

	// Frame memory, byte count stored next to each word
	logic [$bits(bytes_valid_t)+$bits(word_t)-1:0] mem [BUF_WORDS];

	// Pointers carry one extra wrap bit so fill levels are a plain difference
	logic [AW:0] wr_ptr;
	logic [AW:0] commit_ptr;
	logic [AW:0] rd_ptr;
	logic [AW:0] fill;
	logic        buf_full;
	logic        mem_we;

	// Metadata queue
	vlan_id_t    meta_vlan [META_DEPTH];
	frame_len_t  meta_len  [META_DEPTH];
	logic [MW:0] meta_wr;
	logic [MW:0] meta_rd;
	logic        meta_full;

	// Frame being written
	buf_state_t  state;
	frame_len_t  cur_len;
	vlan_id_t    cur_vlan;

	// Frame being read
	frame_len_t  rd_count;
	logic        pop_ok;
	logic        pop_last;

	// Everything behind the read pointer is in use, committed or not
	assign fill      = wr_ptr - rd_ptr;
	assign buf_full  = (fill == (AW+1)'(BUF_WORDS));
	assign meta_full = ((meta_wr - meta_rd) == (MW+1)'(META_DEPTH));
	assign mem_we    = (state == WRITING) && un_data_valid && !un_start && !buf_full;

	// Oldest committed frame
	assign frame_avail = (meta_wr != meta_rd);
	assign frame_vlan  = meta_vlan[meta_rd[MW-1:0]];
	assign frame_len   = meta_len[meta_rd[MW-1:0]];

	assign pop_ok   = pop && frame_avail;
	assign pop_last = (rd_count == frame_len - 10'd1);

	// Write side FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state               <= IDLE;
			wr_ptr              <= '0;
			commit_ptr          <= '0;
			meta_wr             <= '0;
			cur_len             <= '0;
			frame_committed     <= 1'b0;
			frame_overflow      <= 1'b0;
			frame_policy_drop   <= 1'b0;
			frame_upstream_drop <= 1'b0;
		end else begin
			frame_committed     <= 1'b0;
			frame_overflow      <= 1'b0;
			frame_policy_drop   <= 1'b0;
			frame_upstream_drop <= 1'b0;

			if (un_start) begin
				// Any leftover partial frame is abandoned
				wr_ptr  <= commit_ptr;
				cur_len <= '0;
				// No metadata slot means no room for this frame at all
				if (meta_full) begin
					state          <= DISCARD;
					frame_overflow <= 1'b1;
				end else begin
					state <= WRITING;
				end
			end else begin
				case (state)
					WRITING: begin
						if (un_drop) begin
							wr_ptr              <= commit_ptr;
							frame_policy_drop   <= un_policy_drop;
							frame_upstream_drop <= !un_policy_drop;
							state               <= IDLE;
						end else if (un_commit) begin
							meta_vlan[meta_wr[MW-1:0]] <= cur_vlan;
							meta_len[meta_wr[MW-1:0]]  <= cur_len;
							meta_wr         <= meta_wr + 1'b1;
							commit_ptr      <= wr_ptr;
							frame_committed <= 1'b1;
							state           <= IDLE;
						end else if (un_data_valid) begin
							if (buf_full) begin
								// Out of memory, throw away the partial frame
								wr_ptr         <= commit_ptr;
								frame_overflow <= 1'b1;
								state          <= DISCARD;
							end else begin
								wr_ptr  <= wr_ptr + 1'b1;
								cur_len <= cur_len + 10'd1;
							end
						end
					end

					// Wait out the end of the frame, it was already counted
					DISCARD: begin
						if (un_commit || un_drop)
							state <= IDLE;
					end

					default: begin
						state <= IDLE;
					end
				endcase
			end
		end
	end

	// VLAN arrives once per frame at the tag slot
	always_ff @(posedge clk) begin
		if (un_vlan_valid)
			cur_vlan <= un_vlan;
	end

	// Memory write port
	always_ff @(posedge clk) begin
		if (mem_we)
			mem[wr_ptr[AW-1:0]] <= {un_bytes_valid, un_data};
	end

	// Memory read port, data shows up the cycle after pop
	always_ff @(posedge clk) begin
		if (pop_ok)
			{out_bytes_valid, out_data} <= mem[rd_ptr[AW-1:0]];
	end

	// Read side, walks the oldest frame and retires its metadata on the last word
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr    <= '0;
			meta_rd   <= '0;
			rd_count  <= '0;
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else begin
			out_valid <= pop_ok;
			out_last  <= pop_ok && pop_last;
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
				if (pop_last) begin
					rd_count <= '0;
					meta_rd  <= meta_rd + 1'b1;
				end else begin
					rd_count <= rd_count + 10'd1;
				end
			end
		end
	end

endmodule

/* verilog/vlan_untagger.sv */
`timescale 1ns/1ps

// Strips the 802.1q tag from received frames and attaches a VLAN ID
//
// Tagged frames get the VID from the tag, untagged frames get port_vlan
// Admission policy from the two enables
//   tagged and untagged allowed   native VLAN mode
//   tagged allowed only           trunk mode
//   untagged allowed only         access mode
//   neither allowed               port disabled
module vlan_untagger import eth_ingress_pkg::*; (
	input  logic         clk,
	input  logic         reset,

	// Port configuration
	input  vlan_id_t     port_vlan,
	input  logic         tagged_allowed,
	input  logic         untagged_allowed,

	// Receive bus from the MAC
	input  logic         rx_start,
	input  logic         rx_data_valid,
	input  word_t        rx_data,
	input  bytes_valid_t rx_bytes_valid,
	input  logic         rx_commit,
	input  logic         rx_drop,

	// Untagged bus towards the frame buffer
	output logic         un_start,
	output logic         un_data_valid,
	output word_t        un_data,
	output bytes_valid_t un_bytes_valid,
	output logic         un_commit,
	output logic         un_drop,
	output logic         un_policy_drop,
	output vlan_id_t     un_vlan,
	output logic         un_vlan_valid
);

	// Data words seen so far in this frame, stops counting past the tag slot
	logic [2:0] word_count;

	// Frame is muted until the next start
	logic       dropping;

	// Current word sits in the tag slot
	logic       at_tag_word;

	// Upper half of the word carries the 802.1q TPID
	logic       has_tag;

	// The enable that applies to this frame's kind
	logic       kind_allowed;

	assign at_tag_word  = (word_count == 3'(VLAN_TAG_WORD));
	assign has_tag      = (rx_data[31:16] == TPID_8021Q);
	assign kind_allowed = has_tag ? tagged_allowed : untagged_allowed;

	// Strobes and frame tracking
	always_ff @(posedge clk) begin
		if (reset) begin
			un_start       <= 1'b0;
			un_data_valid  <= 1'b0;
			un_commit      <= 1'b0;
			un_drop        <= 1'b0;
			un_policy_drop <= 1'b0;
			un_vlan_valid  <= 1'b0;
			word_count     <= '0;
			dropping       <= 1'b0;
		end else begin
			// Single cycle strobes default low
			un_data_valid  <= 1'b0;
			un_commit      <= 1'b0;
			un_drop        <= 1'b0;
			un_policy_drop <= 1'b0;
			un_vlan_valid  <= 1'b0;

			// Start always passes through
			un_start <= rx_start;

			// New frame, rearm the counter and unmute
			if (rx_start) begin
				word_count <= '0;
				dropping   <= 1'b0;
			end

			if (rx_drop) begin
				// Upstream drop, forwarded only once per frame
				// A frame already rejected by policy has ended downstream
				if (!dropping)
					un_drop <= 1'b1;
				dropping <= 1'b1;
			end else if (!dropping) begin
				if (rx_commit) begin
					un_commit <= 1'b1;
				end else if (rx_data_valid) begin
					if (!at_tag_word) begin
						un_data_valid <= 1'b1;
					end else begin
						// Tag slot decides the VLAN and the admission
						un_vlan_valid <= 1'b1;

						// Untagged word is real payload, tag word is swallowed
						un_data_valid <= !has_tag && untagged_allowed;

						if (!kind_allowed) begin
							un_drop        <= 1'b1;
							un_policy_drop <= 1'b1;
							dropping       <= 1'b1;
						end
					end

					// Saturate one past the tag slot
					if (word_count <= 3'(VLAN_TAG_WORD))
						word_count <= word_count + 3'd1;
				end
			end
		end
	end

	// Payload path, registered alongside the strobes
	always_ff @(posedge clk) begin
		un_data        <= rx_data;
		un_bytes_valid <= rx_bytes_valid;

		// VID from the tag, otherwise the port VLAN
		if (rx_data_valid && at_tag_word)
			un_vlan <= has_tag ? rx_data[11:0] : port_vlan;
	end

endmodule

/* verilog/eth_ingress_pkg.sv */
package eth_ingress_pkg;

	// One word of the receive bus, first octet in the top byte
	typedef logic [31:0] word_t;

	// Valid bytes in a word, 1 to 4
	typedef logic [2:0] bytes_valid_t;

	// 802.1q VLAN identifier
	typedef logic [11:0] vlan_id_t;

	// Frame length counted in bus words
	typedef logic [9:0] frame_len_t;

	// Statistics counter, saturates at all ones
	typedef logic [15:0] stat_count_t;

	// Tag protocol identifier in the upper half of a tag word
	localparam logic [15:0] TPID_8021Q = 16'h8100;

	// Words 0 to 2 carry the MAC addresses
	// Word 3 is the tag slot, exactly four octets
	localparam int unsigned VLAN_TAG_WORD = 3;

	// Write side of the frame buffer
	// IDLE     waiting for a frame start
	// WRITING  storing words of an admitted frame
	// DISCARD  swallowing the rest of a frame that did not fit
	typedef enum logic [1:0] {
		IDLE,
		WRITING,
		DISCARD
	} buf_state_t;

endpackage
